// File: compile.f
pel_pkg.sv
coef_pkg.sv
flux_fifo.sv
fifo_bank.sv
scaler.sv
shifter.sv
pel_scaler_top.sv
tb_pel_scaler.sv

// File: Bender.yml
package:
  name: pel_scaler

sources:
  - pel_pkg.sv
  - coef_pkg.sv
  - flux_fifo.sv
  - fifo_bank.sv
  - scaler.sv
  - shifter.sv
  - pel_scaler_top.sv
  - target: test
    files:
      - tb_pel_scaler.sv

// File: tb_pel_scaler.sv
module tb_pel_scaler;

    timeunit 1ns;
    timeprecision 1ps;

    import pel_pkg::*;
    import coef_pkg::*;

    localparam int FLUX   = 2;
    localparam int DEPTH  = 4;
    localparam int CLK_NS = 20;

    // words per test
    localparam int N_UNITY  = 16;
    localparam int N_ROUNDS = 4;
    localparam int N_SCALE  = 8;
    localparam int N_CONC   = 24;
    localparam int N_BACK   = 3 * DEPTH;

    localparam int TOTAL_WORDS = N_UNITY + N_ROUNDS * FLUX * N_SCALE
                                 + FLUX * N_CONC + FLUX * N_BACK;
    localparam int WATCHDOG_NS = TOTAL_WORDS * 20 * CLK_NS + 2000;
    localparam int DRAIN_LIMIT = 200;

    logic             clk;
    logic             rst_n;
    logic [FLUX-1:0]  in_write;
    pel_t [FLUX-1:0]  in_din;
    logic [FLUX-1:0]  in_full;
    coef_t [FLUX-1:0] coef;
    logic [FLUX-1:0]  out_read;
    pel_t [FLUX-1:0]  out_dout;
    logic [FLUX-1:0]  out_empty;

    // expected pels per flux, oldest first
    pel_t exp_q0[$];
    pel_t exp_q1[$];

    integer seed;
    string  current_test;
    int     test_errors;
    int     pass_count;
    int     fail_count;

    pel_scaler_top #(
        .FLUX  (FLUX),
        .DEPTH (DEPTH)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_write  (in_write),
        .in_din    (in_din),
        .in_full   (in_full),
        .coef      (coef),
        .out_read  (out_read),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_NS / 2) clk = ~clk;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before the tests completed");
        $display("Regression failed");
        $finish;
    end

    // unsigned 32 bit product, fraction dropped, low 16 bits kept
    function automatic pel_t expected_pel(input pel_t p, input coef_t c);
        logic [31:0] prod;
        prod = {16'h0000, p} * {16'h0000, c};
        return pel_t'(prod >> FRAC_BITS);
    endfunction

    function automatic int pending();
        return exp_q0.size() + exp_q1.size();
    endfunction

    task automatic check_pel(input string name, input pel_t expected, input pel_t actual);
        if (expected !== actual)
        begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s: %s", current_test, what);
        test_errors++;
    endtask

    task automatic push_expected(input int f, input pel_t value);
        if (f == 0)
        begin
            exp_q0.push_back(value);
        end
        else
        begin
            exp_q1.push_back(value);
        end
    endtask

    task automatic compare_output(input int f, input pel_t actual);
        pel_t expected;
        if ((f == 0 && exp_q0.size() == 0) || (f == 1 && exp_q1.size() == 0))
        begin
            report_error($sformatf("flux %0d delivered %h while nothing was expected",
                                   f, actual));
        end
        else
        begin
            expected = (f == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
            check_pel($sformatf("%s flux %0d", current_test, f), expected, actual);
        end
    endtask

    // scoreboard, every accepted input word
    always @(posedge clk)
    begin
        for (int f = 0; f < FLUX; f++)
        begin
            if (rst_n && in_write[f] && !in_full[f])
            begin
                push_expected(f, expected_pel(in_din[f], coef[f]));
            end
        end
    end

    // compare, every accepted output word
    always @(posedge clk)
    begin
        for (int f = 0; f < FLUX; f++)
        begin
            if (rst_n && out_read[f] && !out_empty[f])
            begin
                compare_output(f, out_dout[f]);
            end
        end
    end

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic finish_test();
        if (pending() != 0)
        begin
            report_error($sformatf("%0d expected words were never delivered", pending()));
            exp_q0.delete();
            exp_q1.delete();
        end
        if (test_errors == 0)
        begin
            pass_count++;
            $display("test %s: ok", current_test);
        end
        else
        begin
            fail_count++;
            $display("test %s: FAILED with %0d errors", current_test, test_errors);
        end
    endtask

    // writes only where in_full is low, so every driven word is accepted
    task automatic send_words(input logic [FLUX-1:0] lanes, input int count,
                              input bit max_first);
        int              sent [FLUX];
        int              cycles;
        logic [FLUX-1:0] busy;
        for (int f = 0; f < FLUX; f++)
        begin
            sent[f] = 0;
        end
        cycles = 0;
        busy   = lanes;
        while (busy != '0 && cycles < 4 * DRAIN_LIMIT)
        begin
            @(negedge clk);
            in_write = '0;
            for (int f = 0; f < FLUX; f++)
            begin
                if (busy[f] && !in_full[f])
                begin
                    in_write[f] = 1'b1;
                    if (max_first && sent[f] == 0)
                    begin
                        in_din[f] = {PEL_WIDTH{1'b1}};
                    end
                    else
                    begin
                        in_din[f] = pel_t'($random(seed));
                    end
                    sent[f]++;
                    if (sent[f] == count)
                    begin
                        busy[f] = 1'b0;
                    end
                end
            end
            cycles++;
        end
        @(negedge clk);
        in_write = '0;
        if (busy != '0)
        begin
            report_error("input stayed full and not all words could be written");
        end
    endtask

    // read everything out, then stay quiet a while to catch duplicates
    task automatic drain();
        int cycles;
        @(negedge clk);
        out_read = '1;
        cycles   = 0;
        while ((pending() != 0 || out_empty != '1) && cycles < DRAIN_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (pending() != 0 || out_empty != '1)
        begin
            report_error($sformatf("output did not drain, %0d words still expected",
                                   pending()));
        end
        repeat (2 * DEPTH) @(negedge clk);
    endtask

    task automatic fill_lane(input int f, output int accepted);
        int cycles;
        accepted = 0;
        cycles   = 0;
        @(negedge clk);
        while (!in_full[f] && cycles < DRAIN_LIMIT)
        begin
            in_write    = '0;
            in_write[f] = 1'b1;
            in_din[f]   = pel_t'($random(seed));
            accepted++;
            @(negedge clk);
            cycles++;
        end
        in_write = '0;
        if (!in_full[f])
        begin
            report_error($sformatf("input of flux %0d never became full", f));
        end
    endtask

    initial
    begin
        int accepted;
        seed         = 32'hc63423ad;
        pass_count   = 0;
        fail_count   = 0;
        test_errors  = 0;
        current_test = "init";
        rst_n        = 1'b0;
        in_write     = '0;
        in_din       = '0;
        coef         = '0;
        out_read     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_state");
        @(negedge clk);
        for (int f = 0; f < FLUX; f++)
        begin
            check_flag($sformatf("reset_state out_empty[%0d]", f), 1'b1, out_empty[f]);
            check_flag($sformatf("reset_state in_full[%0d]", f), 1'b0, in_full[f]);
        end
        finish_test();

        start_test("unity_gain");
        coef[0]  = COEF_ONE;
        coef[1]  = COEF_ONE;
        out_read = '1;
        send_words(2'b01, N_UNITY, 1'b0);
        drain();
        finish_test();

        // first round at the largest gain, later rounds random
        start_test("scaling");
        for (int r = 0; r < N_ROUNDS; r++)
        begin
            @(negedge clk);
            for (int f = 0; f < FLUX; f++)
            begin
                coef[f] = (r == 0) ? {16{1'b1}} : coef_t'($random(seed));
            end
            send_words(2'b01, N_SCALE, 1'b1);
            send_words(2'b10, N_SCALE, 1'b1);
            drain();
        end
        finish_test();

        start_test("concurrent");
        @(negedge clk);
        out_read = '1;
        for (int f = 0; f < FLUX; f++)
        begin
            coef[f] = coef_t'($random(seed));
        end
        send_words(2'b11, N_CONC, 1'b0);
        drain();
        finish_test();

        // output held, each lane fills all three FIFO stages
        start_test("back_pressure");
        @(negedge clk);
        out_read = '0;
        for (int f = 0; f < FLUX; f++)
        begin
            coef[f] = coef_t'($random(seed));
        end
        for (int f = 0; f < FLUX; f++)
        begin
            fill_lane(f, accepted);
            check_count($sformatf("back_pressure flux %0d accepted", f), N_BACK, accepted);
        end
        drain();
        finish_test();

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: pel_scaler_top.sv
module pel_scaler_top #(
    parameter int FLUX  = 2,
    parameter int DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic            [FLUX-1:0]        in_write,
    input  pel_pkg::pel_t   [FLUX-1:0]        in_din,
    output logic            [FLUX-1:0]        in_full,
    input  coef_pkg::coef_t [FLUX-1:0]        coef,
    input  logic            [FLUX-1:0]        out_read,
    output pel_pkg::pel_t   [FLUX-1:0]        out_dout,
    output logic            [FLUX-1:0]        out_empty
);

    import pel_pkg::*;

    // input bank to scaler
    pel_t [FLUX-1:0] in_dout;
    logic [FLUX-1:0] in_empty;
    logic [FLUX-1:0] in_read;

    // scaler to middle bank to shifter
    logic [FLUX-1:0] mid_write;
    acc_t [FLUX-1:0] mid_din;
    logic [FLUX-1:0] mid_full;
    logic [FLUX-1:0] mid_read;
    acc_t [FLUX-1:0] mid_dout;
    logic [FLUX-1:0] mid_empty;

    // shifter to output bank
    logic [FLUX-1:0] sh_write;
    pel_t [FLUX-1:0] sh_din;
    logic [FLUX-1:0] sh_full;

    fifo_bank #(
        .FLUX  (FLUX),
        .WIDTH (PEL_WIDTH),
        .DEPTH (DEPTH)
    ) in_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .write (in_write),
        .din   (in_din),
        .full  (in_full),
        .read  (in_read),
        .dout  (in_dout),
        .empty (in_empty)
    );

    scaler #(
        .FLUX (FLUX)
    ) u_scaler (
        .in_empty  (in_empty),
        .in_dout   (in_dout),
        .in_read   (in_read),
        .coef      (coef),
        .out_full  (mid_full),
        .out_write (mid_write),
        .out_din   (mid_din)
    );

    // products travel at full 32 bit width
    fifo_bank #(
        .FLUX  (FLUX),
        .WIDTH (ACC_WIDTH),
        .DEPTH (DEPTH)
    ) mid_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .write (mid_write),
        .din   (mid_din),
        .full  (mid_full),
        .read  (mid_read),
        .dout  (mid_dout),
        .empty (mid_empty)
    );

    shifter #(
        .FLUX (FLUX)
    ) u_shifter (
        .in_empty  (mid_empty),
        .in_dout   (mid_dout),
        .in_read   (mid_read),
        .out_full  (sh_full),
        .out_write (sh_write),
        .out_din   (sh_din)
    );

    fifo_bank #(
        .FLUX  (FLUX),
        .WIDTH (PEL_WIDTH),
        .DEPTH (DEPTH)
    ) out_bank (
        .clk   (clk),
        .rst_n (rst_n),
        .write (sh_write),
        .din   (sh_din),
        .full  (sh_full),
        .read  (out_read),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

// File: shifter.sv
module shifter #(
    parameter int FLUX = 2
) (
    input  logic          [FLUX-1:0] in_empty,
    input  pel_pkg::acc_t [FLUX-1:0] in_dout,
    output logic          [FLUX-1:0] in_read,
    input  logic          [FLUX-1:0] out_full,
    output logic          [FLUX-1:0] out_write,
    output pel_pkg::pel_t [FLUX-1:0] out_din
);

    import pel_pkg::*;
    import coef_pkg::*;

    localparam int TAG_WIDTH = (FLUX > 1) ? $clog2(FLUX) : 1;

    logic [TAG_WIDTH-1:0] tag;
    logic                 found;

    // priority pick, flux 0 wins
    always_comb
    begin
        tag   = '0;
        found = 1'b0;
        for (int i = 0; i < FLUX; i++)
        begin
            if (!found && !in_empty[i] && !out_full[i])
            begin
                tag   = TAG_WIDTH'(i);
                found = 1'b1;
            end
        end
    end

    // strobes only on the selected lane
    always_comb
    begin
        in_read   = '0;
        out_write = '0;
        if (found)
        begin
            in_read[tag]   = 1'b1;
            out_write[tag] = 1'b1;
        end
    end

    // the shift is just wiring, so every lane gets its own result
    // only the lane flagged in out_write is meaningful
    always_comb
    begin
        for (int i = 0; i < FLUX; i++)
        begin
            out_din[i] = pel_t'(in_dout[i] >> FRAC_BITS);
        end
    end

endmodule

// File: scaler.sv
module scaler #(
    parameter int FLUX = 2
) (
    input  logic                            [FLUX-1:0] in_empty,
    input  pel_pkg::pel_t                   [FLUX-1:0] in_dout,
    output logic                            [FLUX-1:0] in_read,
    input  coef_pkg::coef_t                 [FLUX-1:0] coef,
    input  logic                            [FLUX-1:0] out_full,
    output logic                            [FLUX-1:0] out_write,
    output pel_pkg::acc_t                   [FLUX-1:0] out_din
);

    import pel_pkg::*;

    // a single flux still needs a one bit tag
    localparam int TAG_WIDTH = (FLUX > 1) ? $clog2(FLUX) : 1;

    logic [TAG_WIDTH-1:0] tag;
    logic                 found;
    acc_t                 product;

    // lowest flux with a word waiting and room downstream
    always_comb
    begin
        tag   = '0;
        found = 1'b0;
        for (int i = 0; i < FLUX; i++)
        begin
            if (!found && !in_empty[i] && !out_full[i])
            begin
                tag   = TAG_WIDTH'(i);
                found = 1'b1;
            end
        end
    end

    // one multiplier on the selected lane
    // both operands widened first so the product keeps 32 bits
    always_comb
    begin
        product = acc_t'(in_dout[tag]) * acc_t'(coef[tag]);
    end

    always_comb
    begin
        in_read   = '0;
        out_write = '0;
        out_din   = '0;
        if (found)
        begin
            in_read[tag]   = 1'b1;
            out_write[tag] = 1'b1;
            out_din[tag]   = product;
        end
    end

endmodule

// File: fifo_bank.sv
module fifo_bank #(
    parameter int FLUX  = 2,
    parameter int WIDTH = 16,
    parameter int DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [FLUX-1:0]            write,
    input  logic [FLUX-1:0][WIDTH-1:0] din,
    output logic [FLUX-1:0]            full,
    input  logic [FLUX-1:0]            read,
    output logic [FLUX-1:0][WIDTH-1:0] dout,
    output logic [FLUX-1:0]            empty
);

    // one independent queue per flux, no coupling between lanes
    genvar f;

    generate
        for (f = 0; f < FLUX; f++)
        begin : g_flux
            flux_fifo #(
                .WIDTH (WIDTH),
                .DEPTH (DEPTH)
            ) u_fifo (
                .clk   (clk),
                .rst_n (rst_n),
                .write (write[f]),
                .din   (din[f]),
                .full  (full[f]),
                .read  (read[f]),
                .dout  (dout[f]),
                .empty (empty[f])
            );
        end
    endgenerate

endmodule

// File: flux_fifo.sv
module flux_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             write,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             read,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    // a depth of one still needs a one bit pointer
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 wr_en;
    logic                 rd_en;

    // writes on full and reads on empty are dropped
    assign wr_en = write & ~full;
    assign rd_en = read & ~empty;

    assign full  = (count == CNT_WIDTH'(DEPTH));
    assign empty = (count == '0);

    // head word, valid whenever empty is low
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // count moves only when exactly one side is active
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: coef_pkg.sv
package coef_pkg;

    // per-flux gain, unsigned Q5.11
    localparam int COEF_WIDTH = 16;

    // fraction bits of the gain, also the shifter's right shift
    localparam int FRAC_BITS = 11;

    // gain format
    typedef logic [COEF_WIDTH-1:0] coef_t;

    // 1.0 in Q5.11
    localparam coef_t COEF_ONE = coef_t'(1 << FRAC_BITS);

endpackage

// File: pel_pkg.sv
package pel_pkg;

    // pixel samples as they enter and leave the subsystem
    localparam int PEL_WIDTH = 16;

    // scaled product, a pel times a Q5.11 gain, before the fraction is dropped
    localparam int ACC_WIDTH = 32;

    // unsigned pixel sample
    typedef logic [PEL_WIDTH-1:0] pel_t;

    // unsigned product, truncated to ACC_WIDTH bits
    typedef logic [ACC_WIDTH-1:0] acc_t;

endpackage
